// File: rtl/lsu.sv
//************************************************
// Load/store unit top level
// DC1 address stage, DC2 DCCM access, DC3 load
// alignment, APB configuration registers
//************************************************
`timescale 1ns/1ps

module lsu (
   input  logic               clk,
   input  logic               rst_n,
   // Request
   input  logic               req_valid,
   input  logic               req_store,
   input  lsu_pkg::size_t     req_size,
   input  logic               req_unsigned,
   input  lsu_pkg::addr_t     rs1,
   input  lsu_pkg::offset_t   offset,
   input  lsu_pkg::data_t     store_data,
   // Response two edges after the request
   output logic               resp_valid,
   output lsu_pkg::data_t     resp_data,
   output lsu_pkg::cause_t    resp_cause,
   output lsu_pkg::addr_t     resp_addr,
   output logic               resp_trigger,
   // APB slave
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  lsu_pkg::apb_addr_t paddr,
   input  lsu_pkg::data_t     pwdata,
   output lsu_pkg::data_t     prdata,
   output logic               pready,
   output logic               pslverr
);
   import lsu_pkg::*;

   logic   dc2_valid;
   logic   dc2_store;
   addr_t  dc2_addr;
   size_t  dc2_size;
   logic   dc2_unsigned;
   cause_t dc2_cause;
   logic   dc2_trigger;

   lsu_cfg_if  cfg_if ();
   lsu_dccm_if dccm_if ();

   lsu_csr_apb csr_apb_inst (
      .clk, .rst_n,
      .psel, .penable, .pwrite, .paddr, .pwdata,
      .prdata, .pready, .pslverr,
      .cfg (cfg_if.csr)
   );

   lsu_addr_stage addr_stage_inst (
      .clk, .rst_n,
      .req_valid, .req_store, .req_size, .req_unsigned,
      .rs1, .offset, .store_data,
      .cfg  (cfg_if.stage),
      .dccm (dccm_if.stage),
      .dc2_valid, .dc2_store, .dc2_addr, .dc2_size,
      .dc2_unsigned, .dc2_cause, .dc2_trigger
   );

   lsu_dccm_ram dccm_ram_inst (
      .clk,
      .dccm (dccm_if.ram)
   );

   lsu_load_align load_align_inst (
      .clk, .rst_n,
      .dc2_valid, .dc2_addr, .dc2_size, .dc2_unsigned,
      .dc2_cause, .dc2_trigger, .dc2_store,
      .dccm (dccm_if.align),
      .resp_valid, .resp_data, .resp_cause, .resp_addr, .resp_trigger
   );

endmodule

// File: rtl/lsu_addr_stage.sv
//************************************************
// LSU DC1 address stage
// Effective address, alignment and region checks,
// trigger match, store lanes, DC2 register
//************************************************
`timescale 1ns/1ps

module lsu_addr_stage (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             req_valid,
   input  logic             req_store,
   input  lsu_pkg::size_t   req_size,
   input  logic             req_unsigned,
   input  lsu_pkg::addr_t   rs1,
   input  lsu_pkg::offset_t offset,
   input  lsu_pkg::data_t   store_data,
   lsu_cfg_if.stage         cfg,
   lsu_dccm_if.stage        dccm,
   output logic             dc2_valid,
   output logic             dc2_store,
   output lsu_pkg::addr_t   dc2_addr,
   output lsu_pkg::size_t   dc2_size,
   output logic             dc2_unsigned,
   output lsu_pkg::cause_t  dc2_cause,
   output logic             dc2_trigger
);
   import lsu_pkg::*;

   addr_t    dc1_addr;
   logic     misalign;
   logic     out_of_region;
   cause_t   dc1_cause;
   logic     dc1_trigger;
   byte_en_t dc1_byte_en;
   data_t    dc1_wr_data;
   byte_en_t dc2_byte_en;
   data_t    dc2_wr_data;
   logic     dc2_ok;

   assign dc1_addr = rs1 + {{20{offset[11]}}, offset};   // Sign-extended offset

   assign misalign = (req_size == SIZE_HALF && dc1_addr[0]) ||
                     (req_size == SIZE_WORD && dc1_addr[1:0] != 2'b00);
   assign out_of_region = dc1_addr[31:DCCM_REGION_LSB] != cfg.dccm_base[31:DCCM_REGION_LSB];

   assign dc1_cause = misalign      ? CAUSE_MISALIGN :
                      out_of_region ? CAUSE_ACCESS   : CAUSE_NONE;

   assign dc1_trigger = (dc1_addr == cfg.trig_addr) &&
                        (req_store ? cfg.trig_store_en : cfg.trig_load_en);

   // Byte enables and lane placement from size and low address bits
   always_comb begin
      case (req_size)
         SIZE_BYTE: dc1_byte_en = byte_en_t'(4'b0001) << dc1_addr[1:0];
         SIZE_HALF: dc1_byte_en = byte_en_t'(4'b0011) << dc1_addr[1:0];
         default:   dc1_byte_en = 4'b1111;
      endcase
      dc1_wr_data = store_data << {dc1_addr[1:0], 3'b000};
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         dc2_valid <= 1'b0;
      else
         dc2_valid <= req_valid;
   end

   always_ff @(posedge clk) begin
      dc2_store    <= req_store;
      dc2_addr     <= dc1_addr;
      dc2_size     <= req_size;
      dc2_unsigned <= req_unsigned;
      dc2_cause    <= dc1_cause;
      dc2_trigger  <= dc1_trigger;
      dc2_byte_en  <= dc1_byte_en;
      dc2_wr_data  <= dc1_wr_data;
   end

   assign dc2_ok = dc2_valid && dc2_cause == CAUSE_NONE;  // Faults never reach memory

   assign dccm.rden    = dc2_ok & ~dc2_store;
   assign dccm.wren    = dc2_ok & dc2_store;
   assign dccm.idx     = dc2_addr[DCCM_REGION_LSB-1:2];
   assign dccm.byte_en = dc2_byte_en;
   assign dccm.wr_data = dc2_wr_data;

   assign cfg.fault_pulse = dc2_valid && dc2_cause != CAUSE_NONE;

endmodule

// File: rtl/lsu_cfg_if.sv
//************************************************
// Configuration interface
// Register block settings to the address stage,
// fault events back to the counter
//************************************************
`timescale 1ns/1ps

interface lsu_cfg_if;
   import lsu_pkg::*;

   addr_t dccm_base;       // Low region bits are zero
   addr_t trig_addr;
   logic  trig_load_en;
   logic  trig_store_en;
   logic  fault_pulse;     // One cycle per faulting request

   modport csr (output dccm_base, trig_addr, trig_load_en, trig_store_en,
                input  fault_pulse);

   modport stage (input  dccm_base, trig_addr, trig_load_en, trig_store_en,
                  output fault_pulse);

endinterface

// File: rtl/lsu_csr_apb.sv
//************************************************
// LSU configuration registers on APB
// DCCM base, data trigger address and enables,
// saturating fault counter. Zero wait states
//************************************************
`timescale 1ns/1ps

module lsu_csr_apb (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  lsu_pkg::apb_addr_t paddr,
   input  lsu_pkg::data_t     pwdata,
   output lsu_pkg::data_t     prdata,
   output logic               pready,
   output logic               pslverr,
   lsu_cfg_if.csr             cfg
);
   import lsu_pkg::*;

   logic [31:DCCM_REGION_LSB] base_hi;     // Only the region bits are stored
   addr_t                     base_full;
   addr_t                     trig_addr_q;
   logic                      load_en_q;
   logic                      store_en_q;
   fault_cnt_t                fault_cnt;
   logic                      reg_hit;
   logic                      wr_en;

   assign wr_en  = psel & penable & pwrite;
   assign pready = 1'b1;
   assign pslverr = psel & penable & ~reg_hit;

   assign base_full = {base_hi, {DCCM_REGION_LSB{1'b0}}};

   //************************************************
   // Read mux and offset decode
   //************************************************
   always_comb begin
      prdata  = '0;
      reg_hit = 1'b1;
      case (paddr)
         REG_DCCM_BASE: prdata = base_full;
         REG_TRIG_ADDR: prdata = trig_addr_q;
         REG_TRIG_CTRL: prdata = data_t'({store_en_q, load_en_q});
         REG_FAULT_CNT: prdata = data_t'(fault_cnt);
         default:       reg_hit = 1'b0;     // Unmapped offset
      endcase
   end

   //************************************************
   // Register writes and fault counter
   //************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         base_hi     <= DCCM_BASE_RESET[31:DCCM_REGION_LSB];
         trig_addr_q <= '0;
         load_en_q   <= 1'b0;
         store_en_q  <= 1'b0;
         fault_cnt   <= '0;
      end else begin
         if (wr_en && paddr == REG_DCCM_BASE)
            base_hi <= pwdata[31:DCCM_REGION_LSB];
         if (wr_en && paddr == REG_TRIG_ADDR)
            trig_addr_q <= pwdata;
         if (wr_en && paddr == REG_TRIG_CTRL) begin
            load_en_q  <= pwdata[0];
            store_en_q <= pwdata[1];
         end
         // Clear beats a fault in the same cycle
         if (wr_en && paddr == REG_FAULT_CNT)
            fault_cnt <= '0;
         else if (cfg.fault_pulse && fault_cnt != '1)
            fault_cnt <= fault_cnt + 1'b1;     // Saturates at all ones
      end
   end

   assign cfg.dccm_base     = base_full;
   assign cfg.trig_addr     = trig_addr_q;
   assign cfg.trig_load_en  = load_en_q;
   assign cfg.trig_store_en = store_en_q;

endmodule

// File: rtl/lsu_dccm_if.sv
//************************************************
// DCCM interface
// Word request from DC2, read data back in DC3
//************************************************
`timescale 1ns/1ps

interface lsu_dccm_if;
   import lsu_pkg::*;

   logic      rden;
   logic      wren;
   dccm_idx_t idx;
   byte_en_t  byte_en;
   data_t     wr_data;      // Already shifted into its lanes
   data_t     rd_data;      // Valid the cycle after rden

   modport stage (output rden, wren, idx, byte_en, wr_data);

   modport align (input rd_data);

   modport ram (input  rden, wren, idx, byte_en, wr_data,
                output rd_data);

endinterface

// File: rtl/lsu_dccm_ram.sv
//************************************************
// DCCM data memory
// 256 x 32 synchronous RAM with byte writes
//************************************************
`timescale 1ns/1ps

module lsu_dccm_ram (
   input logic     clk,
   lsu_dccm_if.ram dccm
);
   import lsu_pkg::*;

   data_t mem [DCCM_WORDS];
   data_t rd_q;

   // Write one lane per enable bit at the clock edge
   always_ff @(posedge clk) begin
      if (dccm.wren) begin
         for (int b = 0; b < 4; b++) begin
            if (dccm.byte_en[b])
               mem[dccm.idx][8*b +: 8] <= dccm.wr_data[8*b +: 8];
         end
      end
   end

   // Read data held until the next read
   always_ff @(posedge clk) begin
      if (dccm.rden)
         rd_q <= mem[dccm.idx];
   end

   assign dccm.rd_data = rd_q;

endmodule

// File: rtl/lsu_load_align.sv
//************************************************
// LSU DC3 load alignment
// Byte and half select with sign or zero
// extension, response outputs
//************************************************
`timescale 1ns/1ps

module lsu_load_align (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            dc2_valid,
   input  lsu_pkg::addr_t  dc2_addr,
   input  lsu_pkg::size_t  dc2_size,
   input  logic            dc2_unsigned,
   input  lsu_pkg::cause_t dc2_cause,
   input  logic            dc2_trigger,
   input  logic            dc2_store,
   lsu_dccm_if.align       dccm,
   output logic            resp_valid,
   output lsu_pkg::data_t  resp_data,
   output lsu_pkg::cause_t resp_cause,
   output lsu_pkg::addr_t  resp_addr,
   output logic            resp_trigger
);
   import lsu_pkg::*;

   logic   dc3_valid;
   logic   dc3_store;
   addr_t  dc3_addr;
   size_t  dc3_size;
   logic   dc3_unsigned;
   cause_t dc3_cause;
   logic   dc3_trigger;
   data_t  shifted;
   data_t  ld_data;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         dc3_valid <= 1'b0;
      else
         dc3_valid <= dc2_valid;
   end

   always_ff @(posedge clk) begin
      dc3_store    <= dc2_store;
      dc3_addr     <= dc2_addr;
      dc3_size     <= dc2_size;
      dc3_unsigned <= dc2_unsigned;
      dc3_cause    <= dc2_cause;
      dc3_trigger  <= dc2_trigger;
   end

   assign shifted = dccm.rd_data >> {dc3_addr[1:0], 3'b000};   // Addressed lane to bit 0

   always_comb begin
      case (dc3_size)
         SIZE_BYTE: ld_data = {{24{~dc3_unsigned & shifted[7]}}, shifted[7:0]};
         SIZE_HALF: ld_data = {{16{~dc3_unsigned & shifted[15]}}, shifted[15:0]};
         default:   ld_data = shifted;
      endcase
   end

   assign resp_valid   = dc3_valid;
   assign resp_data    = (!dc3_store && dc3_cause == CAUSE_NONE) ? ld_data : '0;
   assign resp_cause   = dc3_cause;
   assign resp_addr    = dc3_addr;
   assign resp_trigger = dc3_valid & dc3_trigger;

endmodule

// File: rtl/lsu_pkg.sv
//************************************************
// Load/store unit shared definitions
// Widths, vector types, access size and cause
// codes, APB register map and reset values
//************************************************

package lsu_pkg;

   // DCCM geometry
   localparam int DCCM_WORDS      = 256;
   localparam int DCCM_IDX_W      = 8;
   localparam int DCCM_REGION_LSB = 10;   // First bit that selects the 1 KiB region

   typedef logic [31:0]           addr_t;
   typedef logic [31:0]           data_t;
   typedef logic [11:0]           offset_t;   // Treated as signed
   typedef logic [3:0]            byte_en_t;
   typedef logic [1:0]            size_t;
   typedef logic [1:0]            cause_t;
   typedef logic [DCCM_IDX_W-1:0] dccm_idx_t;
   typedef logic [11:0]           apb_addr_t;
   typedef logic [15:0]           fault_cnt_t;

   // Access size codes
   localparam size_t SIZE_BYTE = 2'd0;
   localparam size_t SIZE_HALF = 2'd1;
   localparam size_t SIZE_WORD = 2'd2;

   // Exception causes with misaligned ahead of access fault
   localparam cause_t CAUSE_NONE     = 2'd0;
   localparam cause_t CAUSE_MISALIGN = 2'd1;
   localparam cause_t CAUSE_ACCESS   = 2'd2;

   // APB register offsets
   localparam apb_addr_t REG_DCCM_BASE = 12'h000;
   localparam apb_addr_t REG_TRIG_ADDR = 12'h004;
   localparam apb_addr_t REG_TRIG_CTRL = 12'h008;
   localparam apb_addr_t REG_FAULT_CNT = 12'h00C;

   localparam addr_t DCCM_BASE_RESET = 32'h8000_0000;

endpackage

// File: src.f
rtl/lsu_pkg.sv
rtl/lsu_cfg_if.sv
rtl/lsu_dccm_if.sv
rtl/lsu_csr_apb.sv
rtl/lsu_addr_stage.sv
rtl/lsu_dccm_ram.sv
rtl/lsu_load_align.sv
rtl/lsu.sv
verification/lsu_tb.sv

// File: verification/lsu_tb.sv
//************************************************
// LSU testbench
// Random loads and stores against a reference
// model, APB register checks, latency monitor
//************************************************
`timescale 1ns/1ps

module lsu_tb;
   import lsu_pkg::*;

   localparam int N_RAND  = 400;
   localparam int N_MIS   = 60;
   localparam int N_FAULT = 60;
   localparam int N_TRIG  = 80;
   // Each request takes at most two cycles
   localparam int TEST_CYCLES =
      2 * (3 * DCCM_WORDS + N_RAND + N_RAND / 4 + N_MIS + N_FAULT + 3 * N_TRIG);
   localparam int MARGIN_CYCLES = 500;   // APB traffic and drains

   typedef struct packed {
      int     due;       // Cycle count when resp_valid is expected
      data_t  data;
      cause_t cause;
      addr_t  addr;
      logic   trig;
   } resp_t;

   logic      clk;
   logic      rst_n;
   logic      req_valid;
   logic      req_store;
   size_t     req_size;
   logic      req_unsigned;
   addr_t     rs1;
   offset_t   offset;
   data_t     store_data;
   logic      resp_valid;
   data_t     resp_data;
   cause_t    resp_cause;
   addr_t     resp_addr;
   logic      resp_trigger;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   data_t     pwdata;
   data_t     prdata;
   logic      pready;
   logic      pslverr;

   // Reference model state
   data_t      model_mem [DCCM_WORDS];
   addr_t      model_base;
   addr_t      model_trig;
   logic       model_ld_en;
   logic       model_st_en;
   fault_cnt_t model_faults;
   resp_t      exp_q [$];
   int         cyc = 0;
   string      test_name;

   lsu lsu_inst (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   //************************************************
   // Reporting and drive helpers
   //************************************************
   task automatic stop_run();
      $display("TEST RESULT: FAIL");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check(string what, logic [31:0] exp, logic [31:0] act);
      if (exp !== act) begin
         $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
         stop_run();
      end
   endtask

   task automatic tick();
      @(posedge clk);
      #1;                            // Inputs change away from the edge
   endtask

   task automatic apb_xfer(logic wr, apb_addr_t a, data_t wd,
                           output data_t rd, output logic err);
      psel    = 1'b1;                // Setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = a;
      pwdata  = wd;
      tick();
      penable = 1'b1;                // Access phase
      @(negedge clk);
      check("pready", 1'b1, pready);
      rd  = prdata;
      err = pslverr;
      tick();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic reg_write(apb_addr_t a, data_t d);
      data_t rd;
      logic  err;
      apb_xfer(1'b1, a, d, rd, err);
      check("pslverr on write", 1'b0, err);
   endtask

   task automatic reg_read_check(string what, apb_addr_t a, data_t exp);
      data_t rd;
      logic  err;
      apb_xfer(1'b0, a, '0, rd, err);
      check({what, " pslverr"}, 1'b0, err);
      check(what, exp, rd);
   endtask

   //************************************************
   // Reference model of one access
   //************************************************
   function automatic resp_t model_access(logic st, size_t sz, logic uns, addr_t a, data_t sd);
      resp_t r;
      data_t w;
      int    nb;
      r      = '0;
      r.addr = a;
      nb     = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
      if ((a[1:0] & 2'(nb - 1)) != 2'b00)
         r.cause = CAUSE_MISALIGN;
      else if (a[31:10] != model_base[31:10])
         r.cause = CAUSE_ACCESS;
      r.trig = (a == model_trig) && (st ? model_st_en : model_ld_en);
      if (r.cause != CAUSE_NONE) begin
         if (model_faults != '1)
            model_faults++;
      end else if (st) begin
         for (int b = 0; b < nb; b++)
            model_mem[a[9:2]][8 * (a[1:0] + b) +: 8] = sd[8 * b +: 8];
      end else begin
         w = model_mem[a[9:2]] >> (8 * a[1:0]);
         case (sz)
            SIZE_BYTE: r.data = uns ? {24'h0, w[7:0]} : {{24{w[7]}}, w[7:0]};
            SIZE_HALF: r.data = uns ? {16'h0, w[15:0]} : {{16{w[15]}}, w[15:0]};
            default:   r.data = w;
         endcase
      end
      return r;
   endfunction

   function automatic addr_t region_addr(size_t sz);
      addr_t a;
      a = model_base | addr_t'($urandom_range(1023));
      if (sz == SIZE_HALF)
         a[0] = 1'b0;
      else if (sz == SIZE_WORD)
         a[1:0] = 2'b00;
      return a;
   endfunction

   task automatic idle_cycle();
      req_valid = 1'b0;
      tick();
   endtask

   // One request with a random offset and an occasional idle gap
   task automatic issue(logic st, size_t sz, logic uns, addr_t a, data_t sd);
      resp_t   r;
      offset_t off;
      off          = offset_t'($urandom);
      req_valid    = 1'b1;
      req_store    = st;
      req_size     = sz;
      req_unsigned = uns;
      offset       = off;
      rs1          = a - {{20{off[11]}}, off};
      store_data   = sd;
      r            = model_access(st, sz, uns, a, sd);
      r.due        = cyc + 2;
      exp_q.push_back(r);
      tick();
      if ($urandom_range(3) == 0)
         idle_cycle();
   endtask

   task automatic drain();
      idle_cycle();
      while (exp_q.size() != 0)
         tick();
   endtask

   task automatic load_all_words();
      for (int i = 0; i < DCCM_WORDS; i++)
         issue(1'b0, SIZE_WORD, 1'b0, model_base + 4 * i, $urandom);
      drain();
   endtask

   //************************************************
   // Response monitor at the falling edge
   //************************************************
   always @(negedge clk) begin
      resp_t r;
      if (rst_n) begin
         if (resp_valid && exp_q.size() == 0) begin
            $display("Response arrived with no request in flight at cycle %0d", cyc);
            stop_run();
         end else if (resp_valid) begin
            r = exp_q.pop_front();
            if (r.due != cyc) begin
               $display("Response for address %h came early at cycle %0d", r.addr, cyc);
               stop_run();
            end else begin
               check("resp_data", r.data, resp_data);
               check("resp_cause", r.cause, resp_cause);
               check("resp_addr", r.addr, resp_addr);
               check("resp_trigger", r.trig, resp_trigger);
            end
         end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
            $display("Response missing two edges after request to %h", exp_q[0].addr);
            stop_run();
         end
      end
   end

   initial begin
      #((TEST_CYCLES + MARGIN_CYCLES) * 4);
      $display("Watchdog expired before the tests finished");
      stop_run();
   end

   //************************************************
   // Test sequence
   //************************************************
   initial begin
      addr_t a;
      addr_t old_base;
      data_t d;
      logic  err;
      size_t sz;
      void'($urandom(32'h4052_325c));
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req_store    = 1'b0;
      req_size     = SIZE_BYTE;
      req_unsigned = 1'b0;
      rs1          = '0;
      offset       = '0;
      store_data   = '0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      model_base   = DCCM_BASE_RESET;
      model_trig   = '0;
      model_ld_en  = 1'b0;
      model_st_en  = 1'b0;
      model_faults = '0;
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;

      test_name = "registers";
      reg_read_check("DCCM base", REG_DCCM_BASE, DCCM_BASE_RESET);
      reg_read_check("trigger address", REG_TRIG_ADDR, '0);
      reg_read_check("trigger control", REG_TRIG_CTRL, '0);
      reg_read_check("fault counter", REG_FAULT_CNT, '0);
      d = $urandom | 32'h3FF;              // Low bits are set and read back cleared
      reg_write(REG_DCCM_BASE, d);
      model_base = {d[31:10], 10'h0};
      reg_read_check("DCCM base", REG_DCCM_BASE, model_base);
      apb_xfer(1'b0, 12'h010, '0, d, err);
      check("pslverr unmapped", 1'b1, err);
      apb_xfer(1'b1, 12'hFFC, $urandom, d, err);
      check("pslverr unmapped", 1'b1, err);

      test_name = "memory init";
      for (int i = 0; i < DCCM_WORDS; i++)
         issue(1'b1, SIZE_WORD, 1'b0, model_base + 4 * i, $urandom);
      drain();

      test_name = "random loads and stores";
      for (int i = 0; i < N_RAND; i++) begin
         sz = size_t'($urandom_range(2));
         if (i % 8 == 0) begin
            a = region_addr(SIZE_WORD);      // Store then load of the same word
            issue(1'b1, sz, 1'b0, a, $urandom);
            issue(1'b0, size_t'($urandom_range(2)), $urandom_range(1), a, $urandom);
         end
         issue($urandom_range(1), sz, $urandom_range(1), region_addr(sz), $urandom);
      end
      drain();

      test_name = "misaligned";
      for (int i = 0; i < N_MIS; i++) begin
         sz = $urandom_range(1) ? SIZE_WORD : SIZE_HALF;
         a  = region_addr(SIZE_WORD);
         if (sz == SIZE_HALF)
            a = a + 2 * $urandom_range(1) + 1;
         else
            a = a + $urandom_range(3, 1);
         issue($urandom_range(1), sz, $urandom_range(1), a, $urandom);
      end
      drain();
      load_all_words();

      test_name = "access faults";
      for (int i = 0; i < N_FAULT / 2; i++) begin
         sz = size_t'($urandom_range(2));
         a  = region_addr(sz);
         a[31:10] = a[31:10] ^ (22'd1 << $urandom_range(21));
         issue($urandom_range(1), sz, $urandom_range(1), a, $urandom);
      end
      drain();
      old_base = model_base;
      d = old_base ^ (32'd1 << $urandom_range(31, 10));
      reg_write(REG_DCCM_BASE, d);
      model_base = {d[31:10], 10'h0};
      for (int i = 0; i < N_FAULT / 2; i++) begin
         a = old_base | addr_t'(4 * $urandom_range(255));   // Old region now faults
         issue($urandom_range(1), SIZE_WORD, 1'b0, a, $urandom);
      end
      drain();
      load_all_words();
      reg_read_check("fault counter", REG_FAULT_CNT, model_faults);
      reg_write(REG_FAULT_CNT, $urandom);
      model_faults = '0;
      reg_read_check("fault counter", REG_FAULT_CNT, '0);

      test_name = "trigger";
      model_trig = region_addr(SIZE_BYTE);
      reg_write(REG_TRIG_ADDR, model_trig);
      for (int ctrl = 1; ctrl < 4; ctrl++) begin
         reg_write(REG_TRIG_CTRL, data_t'(ctrl));
         model_ld_en = ctrl[0];
         model_st_en = ctrl[1];
         reg_read_check("trigger control", REG_TRIG_CTRL, data_t'(ctrl));
         for (int i = 0; i < N_TRIG; i++) begin
            sz = size_t'($urandom_range(2));
            a  = $urandom_range(1) ? model_trig : region_addr(sz);
            issue($urandom_range(1), sz, $urandom_range(1), a, $urandom);
         end
         drain();
      end

      repeat (4) tick();                    // No stray responses when idle
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule
